//--- gfx_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// gfx memory format
// pixel, word, mask and address layout of the frame buffer
// ~~~~~~~~~~~~~~~~~~~~
package gfx_pkg;

   // drawing arguments
   localparam int coord_w = 10;
   localparam int radius_w = 12;
   localparam int color_w = 24;

   // memory word and write mask
   localparam int word_w = 128;
   localparam int mask_w = 16;   // 0 enables the byte
   localparam int pixel_w = 32;  // zero pad, then color
   localparam int pixels_per_word = 4;  // slot 0 in the top 32 bits

   // frame select, taken from the frame base
   localparam int frame_sel_lsb = 22;
   localparam int frame_sel_w = 6;

   // memory address, msb first: 6 zero, frame, y, x[9:3], 2 zero
   localparam int addr_w = 31;
   localparam int x_word_w = coord_w - 3;  // one word group is 8 pixels
   localparam int addr_x_lsb = 2;
   localparam int addr_y_lsb = addr_x_lsb + x_word_w;
   localparam int addr_frame_lsb = addr_y_lsb + coord_w;

endpackage

//--- circle_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// circle command registers
// holds host color and arguments, issues the start pulse
// ~~~~~~~~~~~~~~~~~~~~
module circle_regs (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [gfx_pkg::color_w-1:0]       color,
   input  logic                              color_valid,
   input  logic [31:0]                       arguments,
   input  logic                              arguments_valid,
   input  logic [31:0]                       frame_base,
   input  logic                              trigger,
   input  logic                              engine_busy,
   output logic                              start,
   output logic                              ready,
   output logic [gfx_pkg::color_w-1:0]       cfg_color,
   output logic [gfx_pkg::coord_w-1:0]       cfg_x0,
   output logic [gfx_pkg::coord_w-1:0]       cfg_y0,
   output logic [gfx_pkg::radius_w-1:0]      cfg_radius,
   output logic [gfx_pkg::frame_sel_w-1:0]   cfg_frame
);

   logic [gfx_pkg::color_w-1:0] color_q;  // host copy, may change mid-circle
   logic                        accept;

   // start is still high in the cycle after trigger, busy follows it
   assign ready = !engine_busy && !start;
   assign accept = trigger && ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         start <= 1'b0;
         color_q <= '0;
         cfg_color <= '0;
         cfg_x0 <= '0;
         cfg_y0 <= '0;
         cfg_radius <= '0;
         cfg_frame <= '0;
      end else begin
         start <= accept;

         if (color_valid) begin
            color_q <= color;
         end

         if (arguments_valid) begin
            cfg_x0 <= arguments[31:22];
            cfg_y0 <= arguments[21:12];
            cfg_radius <= arguments[11:0];
         end

         // color and frame are frozen for the whole circle
         if (accept) begin
            cfg_color <= color_valid ? color : color_q;
            cfg_frame <= frame_base[gfx_pkg::frame_sel_lsb +: gfx_pkg::frame_sel_w];
         end
      end
   end

endmodule

//--- circle_engine.sv
// ~~~~~~~~~~~~~~~~~~~~
// midpoint circle engine
// walks the outline and hands out one pixel at a time
// ~~~~~~~~~~~~~~~~~~~~
module circle_engine (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           start,
   input  logic [gfx_pkg::coord_w-1:0]    cfg_x0,
   input  logic [gfx_pkg::coord_w-1:0]    cfg_y0,
   input  logic [gfx_pkg::radius_w-1:0]   cfg_radius,
   input  logic                           writer_idle,
   output logic [gfx_pkg::coord_w-1:0]    pixel_x,
   output logic [gfx_pkg::coord_w-1:0]    pixel_y,
   output logic                           pixel_strobe,
   output logic                           engine_busy
);

   localparam int cw = gfx_pkg::coord_w;
   localparam int rw = gfx_pkg::radius_w;
   localparam int acc_w = rw + 3;  // room for f and -2r

   localparam logic signed [acc_w-1:0] acc_one = acc_w'(1);
   localparam logic signed [acc_w-1:0] acc_two = acc_w'(2);

   typedef enum logic [2:0] {
      s_idle,
      s_setup,
      s_emit,
      s_step,
      s_drain
   } state_t;

   state_t state;

   logic [cw-1:0]              x0;
   logic [cw-1:0]              y0;
   logic [rw-1:0]              radius;
   logic signed [acc_w-1:0]    radius_s;
   logic [rw-1:0]              x;
   logic [rw-1:0]              y;
   logic [rw-1:0]              y_next;
   logic signed [acc_w-1:0]    f;
   logic signed [acc_w-1:0]    f_mid;
   logic signed [acc_w-1:0]    ddf_x;
   logic signed [acc_w-1:0]    ddf_y;
   logic signed [acc_w-1:0]    ddf_y_next;
   logic [2:0]                 idx;       // point within the current group
   logic                       cardinal;  // first group of four
   logic                       last;
   logic                       more;
   logic [2:0]                 sel;
   logic [cw-1:0]              dx;
   logic [cw-1:0]              dy;

   assign radius_s = {{(acc_w - rw){1'b0}}, radius};
   assign more = x < y;

   // y half of a midpoint step
   always_comb begin
      y_next = y;
      ddf_y_next = ddf_y;
      f_mid = f;
      if (f >= 0) begin
         y_next = y - 1'b1;
         ddf_y_next = ddf_y + acc_two;
         f_mid = f + ddf_y_next;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= s_idle;
         idx <= '0;
         cardinal <= 1'b0;
      end else begin
         case (state)
            s_idle: begin
               if (start) begin
                  state <= s_setup;
               end
            end
            s_setup: begin
               state <= s_emit;
               idx <= '0;
               cardinal <= 1'b1;
            end
            s_emit: begin
               if (writer_idle) begin
                  idx <= idx + 1'b1;
                  if (last) begin
                     state <= s_step;
                  end
               end
            end
            s_step: begin
               if (more) begin
                  state <= s_emit;
                  idx <= '0;
                  cardinal <= 1'b0;
               end else begin
                  state <= s_drain;
               end
            end
            s_drain: begin
               if (writer_idle) begin
                  state <= s_idle;
               end
            end
            default: state <= s_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == s_idle && start) begin  // inputs frozen for this circle
         x0 <= cfg_x0;
         y0 <= cfg_y0;
         radius <= cfg_radius;
      end
      if (state == s_setup) begin
         f <= acc_one - radius_s;
         ddf_x <= acc_one;
         ddf_y <= -(radius_s + radius_s);
         x <= '0;
         y <= radius;
      end
      if (state == s_step && more) begin
         y <= y_next;
         ddf_y <= ddf_y_next;
         x <= x + 1'b1;
         ddf_x <= ddf_x + acc_two;
         f <= f_mid + ddf_x + acc_two;
      end
   end

   assign last = cardinal ? (idx == 3'd3) : (idx == 3'd7);

   // with x = 0 and y = r the cardinals are octant points 0, 2, 4, 5
   assign sel = cardinal ? {idx[1], ~idx[1] & idx[0], idx[1] & idx[0]} : idx;

   assign dx = sel[2] ? y[cw-1:0] : x[cw-1:0];  // swap for the second octant pair
   assign dy = sel[2] ? x[cw-1:0] : y[cw-1:0];
   assign pixel_x = sel[0] ? x0 - dx : x0 + dx;  // wraps mod 1024
   assign pixel_y = sel[1] ? y0 - dy : y0 + dy;

   assign pixel_strobe = (state == s_emit) && writer_idle;
   assign engine_busy = (state != s_idle) && !(state == s_drain && writer_idle);

endmodule

//--- pixel_writer.sv
// ~~~~~~~~~~~~~~~~~~~~
// pixel writer
// one pixel becomes an address and two masked write beats
// ~~~~~~~~~~~~~~~~~~~~
module pixel_writer (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [gfx_pkg::coord_w-1:0]       pixel_x,
   input  logic [gfx_pkg::coord_w-1:0]       pixel_y,
   input  logic                              pixel_strobe,
   input  logic [gfx_pkg::color_w-1:0]       cfg_color,
   input  logic [gfx_pkg::frame_sel_w-1:0]   cfg_frame,
   input  logic                              af_full,
   input  logic                              wdf_full,
   output logic [gfx_pkg::addr_w-1:0]        af_addr_din,
   output logic                              af_wr_en,
   output logic [gfx_pkg::word_w-1:0]        wdf_din,
   output logic [gfx_pkg::mask_w-1:0]        wdf_mask_din,
   output logic                              wdf_wr_en,
   output logic                              writer_idle
);

   localparam int cw = gfx_pkg::coord_w;
   localparam int slot_w = $clog2(gfx_pkg::pixels_per_word);
   localparam int slot_bytes = gfx_pkg::mask_w / gfx_pkg::pixels_per_word;

   typedef enum logic [1:0] {
      w_idle,
      w_beat1,
      w_beat2
   } wstate_t;

   wstate_t state;

   logic [cw-1:0]                      px;
   logic [cw-1:0]                      py;
   logic [gfx_pkg::color_w-1:0]        color_q;
   logic [gfx_pkg::frame_sel_w-1:0]    frame_q;
   logic [gfx_pkg::pixel_w-1:0]        pad_color;
   logic [slot_w-1:0]                  slot;
   logic                               group_hi;  // pixel lives in beat two
   logic                               beat_hi;
   logic                               beat1_go;
   logic                               beat2_go;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= w_idle;
      end else begin
         case (state)
            w_idle: begin
               if (pixel_strobe) begin
                  state <= w_beat1;
               end
            end
            w_beat1: begin
               if (beat1_go) begin
                  state <= w_beat2;
               end
            end
            w_beat2: begin
               if (beat2_go) begin
                  state <= w_idle;
               end
            end
            default: state <= w_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == w_idle && pixel_strobe) begin
         px <= pixel_x;
         py <= pixel_y;
         color_q <= cfg_color;
         frame_q <= cfg_frame;
      end
   end

   // both fifos must have room for the first beat
   assign beat1_go = (state == w_beat1) && !af_full && !wdf_full;
   assign beat2_go = (state == w_beat2) && !wdf_full;

   assign af_wr_en = beat1_go;
   assign wdf_wr_en = beat1_go || beat2_go;
   assign writer_idle = (state == w_idle);

   always_comb begin
      af_addr_din = '0;
      af_addr_din[gfx_pkg::addr_x_lsb +: gfx_pkg::x_word_w] = px[cw-1 -: gfx_pkg::x_word_w];
      af_addr_din[gfx_pkg::addr_y_lsb +: cw] = py;
      af_addr_din[gfx_pkg::addr_frame_lsb +: gfx_pkg::frame_sel_w] = frame_q;
   end

   assign pad_color = {{(gfx_pkg::pixel_w - gfx_pkg::color_w){1'b0}}, color_q};
   assign wdf_din = {gfx_pkg::pixels_per_word{pad_color}};

   assign slot = px[slot_w-1:0];
   assign group_hi = px[slot_w];
   assign beat_hi = (state == w_beat2);

   // slot 0 owns the top mask nibble, other beat stays fully masked
   always_comb begin
      wdf_mask_din = '1;
      if (group_hi == beat_hi) begin
         wdf_mask_din[(gfx_pkg::pixels_per_word - 1 - slot) * slot_bytes +: slot_bytes] = '0;
      end
   end

endmodule

//--- circle_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// circle drawing top
// registers, midpoint engine and memory writer
// ~~~~~~~~~~~~~~~~~~~~
module circle_top (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [gfx_pkg::color_w-1:0]    color,
   input  logic                           color_valid,
   input  logic [31:0]                    arguments,
   input  logic                           arguments_valid,
   input  logic [31:0]                    frame_base,
   input  logic                           trigger,
   input  logic                           af_full,
   input  logic                           wdf_full,
   output logic                           ready,
   output logic [gfx_pkg::addr_w-1:0]     af_addr_din,
   output logic                           af_wr_en,
   output logic [gfx_pkg::word_w-1:0]     wdf_din,
   output logic [gfx_pkg::mask_w-1:0]     wdf_mask_din,
   output logic                           wdf_wr_en
);

   logic                              start;
   logic                              engine_busy;
   logic                              writer_idle;
   logic [gfx_pkg::color_w-1:0]       cfg_color;
   logic [gfx_pkg::coord_w-1:0]       cfg_x0;
   logic [gfx_pkg::coord_w-1:0]       cfg_y0;
   logic [gfx_pkg::radius_w-1:0]      cfg_radius;
   logic [gfx_pkg::frame_sel_w-1:0]   cfg_frame;
   logic [gfx_pkg::coord_w-1:0]       pixel_x;
   logic [gfx_pkg::coord_w-1:0]       pixel_y;
   logic                              pixel_strobe;

   circle_regs u_regs (
      .clk             (clk),
      .rst             (rst),
      .color           (color),
      .color_valid     (color_valid),
      .arguments       (arguments),
      .arguments_valid (arguments_valid),
      .frame_base      (frame_base),
      .trigger         (trigger),
      .engine_busy     (engine_busy),
      .start           (start),
      .ready           (ready),
      .cfg_color       (cfg_color),
      .cfg_x0          (cfg_x0),
      .cfg_y0          (cfg_y0),
      .cfg_radius      (cfg_radius),
      .cfg_frame       (cfg_frame)
   );

   circle_engine u_engine (
      .clk          (clk),
      .rst          (rst),
      .start        (start),
      .cfg_x0       (cfg_x0),
      .cfg_y0       (cfg_y0),
      .cfg_radius   (cfg_radius),
      .writer_idle  (writer_idle),
      .pixel_x      (pixel_x),
      .pixel_y      (pixel_y),
      .pixel_strobe (pixel_strobe),
      .engine_busy  (engine_busy)
   );

   pixel_writer u_writer (
      .clk          (clk),
      .rst          (rst),
      .pixel_x      (pixel_x),
      .pixel_y      (pixel_y),
      .pixel_strobe (pixel_strobe),
      .cfg_color    (cfg_color),
      .cfg_frame    (cfg_frame),
      .af_full      (af_full),
      .wdf_full     (wdf_full),
      .af_addr_din  (af_addr_din),
      .af_wr_en     (af_wr_en),
      .wdf_din      (wdf_din),
      .wdf_mask_din (wdf_mask_din),
      .wdf_wr_en    (wdf_wr_en),
      .writer_idle  (writer_idle)
   );

endmodule

//--- circle_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~
// memory fifo write protocol checks
// ~~~~~~~~~~~~~~~~~~~~
module circle_asserts (
   input logic clk,
   input logic rst,
   input logic af_full,
   input logic wdf_full,
   input logic af_wr_en,
   input logic wdf_wr_en
);
   timeunit 1ns;
   timeprecision 100ps;

   logic beat_owed;  // second data beat still owed
   int   fail_count = 0;  // failed assertions so far

   always_ff @(posedge clk) begin
      if (rst) begin
         beat_owed <= 1'b0;
      end else if (af_wr_en) begin
         beat_owed <= 1'b1;
      end else if (wdf_wr_en) begin
         beat_owed <= 1'b0;
      end
   end

   a_af_room : assert property (@(posedge clk) disable iff (rst)
      af_wr_en |-> !af_full && !wdf_full)
      else begin
         fail_count++;
         $error("address write into a full fifo");
      end
   a_wdf_room : assert property (@(posedge clk) disable iff (rst)
      wdf_wr_en |-> !wdf_full)
      else begin
         fail_count++;
         $error("data write into a full fifo");
      end
   a_pair : assert property (@(posedge clk) disable iff (rst)
      af_wr_en |-> wdf_wr_en)
      else begin
         fail_count++;
         $error("address write without first data beat");
      end
   a_lone_owed : assert property (@(posedge clk) disable iff (rst)
      (wdf_wr_en && !af_wr_en) |-> beat_owed)
      else begin
         fail_count++;
         $error("extra second data beat");
      end
   a_af_closed : assert property (@(posedge clk) disable iff (rst)
      af_wr_en |-> !beat_owed)
      else begin
         fail_count++;
         $error("new address before second data beat");
      end

endmodule

//--- circle_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// circle drawing testbench
// trace driven circles with random fifo stalls and a check on every write
// ~~~~~~~~~~~~~~~~~~~~
module circle_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int n_tests = 8;
   localparam int n_cols = 9;
   localparam int ready_limit = 20000;

   logic                          clk, rst;
   logic [gfx_pkg::color_w-1:0]   color;
   logic                          color_valid, arguments_valid, trigger;
   logic [31:0]                   arguments, frame_base;
   logic                          af_full, wdf_full, ready, af_wr_en, wdf_wr_en;
   logic [gfx_pkg::addr_w-1:0]    af_addr_din;
   logic [gfx_pkg::word_w-1:0]    wdf_din;
   logic [gfx_pkg::mask_w-1:0]    wdf_mask_din;

   logic [31:0]  trace [0:n_tests*n_cols-1];
   integer       seed;
   logic         stall_en, sample_seen;
   int           errors, test_err, writes;
   logic [23:0]  exp_color;
   logic [5:0]   exp_frame;
   logic [9:0]   sample_x, sample_y, wr_y;
   logic [6:0]   wr_xhi;
   logic [15:0]  mask_one;

   circle_top UUT (.*);

   bind pixel_writer circle_asserts u_asserts (.clk(clk), .rst(rst), .af_full(af_full),
      .wdf_full(wdf_full), .af_wr_en(af_wr_en), .wdf_wr_en(wdf_wr_en));

   always #50 clk = ~clk;

   task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
      if (got !== exp) begin
         errors++;
         test_err++;
         $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic tick;
      @(posedge clk);
      #5;
   endtask

   always @(posedge clk) begin
      #5;
      af_full = stall_en && (($random(seed) & 3) == 0);
      wdf_full = stall_en && (($random(seed) & 3) == 0);
   end

   // outputs are settled at the falling edge
   always @(negedge clk) begin : write_monitor
      int enabled, partial, slot;
      logic [31:0] both;
      if (!rst && af_wr_en) begin
         writes++;
         mask_one = wdf_mask_din;
         wr_y = af_addr_din[18:9];
         wr_xhi = af_addr_din[8:2];
         check("beat one data", wdf_din, {4{8'h00, exp_color}});
         check("address zero fields", {af_addr_din[30:25], af_addr_din[1:0]}, 0);
         check("address frame select", af_addr_din[24:19], exp_frame);
      end else if (!rst && wdf_wr_en) begin
         both = {mask_one, wdf_mask_din};
         enabled = 0;
         partial = 0;
         slot = 0;
         for (int k = 0; k < 8; k++) begin
            if (both[31 - 4*k -: 4] == 4'h0) begin
               enabled++;
               slot = k;
            end else if (both[31 - 4*k -: 4] != 4'hf) begin
               partial++;
            end
         end
         check("beat two data", wdf_din, {4{8'h00, exp_color}});
         check("enabled pixel slots", enabled, 1);
         check("partly masked slots", partial, 0);
         if ({wr_xhi, slot[2:0]} == sample_x && wr_y == sample_y) sample_seen = 1'b1;
      end
   end

   initial begin : main
      int base, cycles;
      logic [31:0] mode;
      clk = 1'b0;
      rst = 1'b1;
      color = '0;
      color_valid = 1'b0;
      arguments = '0;
      arguments_valid = 1'b0;
      frame_base = '0;
      trigger = 1'b0;
      af_full = 1'b0;
      wdf_full = 1'b0;
      stall_en = 1'b0;
      seed = 33222;
      errors = 0;
      $readmemh("circle_trace.txt", trace);
      repeat (16) @(posedge clk);
      #5;
      rst = 1'b0;
      for (int t = 0; t < n_tests; t++) begin
         base = t * n_cols;
         mode = trace[base + 8];
         exp_color = trace[base];
         exp_frame = trace[base + 4][27:22];
         sample_x = trace[base + 6];
         sample_y = trace[base + 7];
         writes = 0;
         sample_seen = 1'b0;
         test_err = 0;
         stall_en = mode[0];
         tick;
         color = exp_color;
         color_valid = !mode[2];  // bit 2 keeps the color stored earlier
         arguments = {trace[base + 1][9:0], trace[base + 2][9:0], trace[base + 3][11:0]};
         arguments_valid = 1'b1;
         frame_base = trace[base + 4];
         tick;
         color_valid = 1'b0;
         arguments_valid = 1'b0;
         trigger = 1'b1;
         tick;
         trigger = 1'b0;
         check("ready after trigger", ready, 0);
         if (mode[1] && t + 1 < n_tests) begin
            repeat (3) tick;
            check("ready while drawing", ready, 0);
            trigger = 1'b1;
            color = trace[base + n_cols];  // meant for the next circle
            color_valid = 1'b1;
            tick;
            trigger = 1'b0;
            color_valid = 1'b0;
         end
         cycles = 0;
         while (!ready && cycles < ready_limit) begin
            tick;
            cycles++;
         end
         if (!ready) begin
            $display("circle %0d never finished, ready stayed low", t);
            $display("TESTS FAILED");
            $finish;
         end
         repeat (4) tick;
         check("address writes", writes, trace[base + 5]);
         check("sample point written", sample_seen, 1);
         $display("test %0d: radius %0d, %0d writes, %0s", t, trace[base + 3], writes,
            test_err == 0 ? "ok" : "mismatch");
      end
      errors += UUT.u_writer.u_asserts.fail_count;
      $display("%0d tests run, %0d errors", n_tests, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- circle_trace.txt
// color x0 y0 radius frame_base writes sample_x sample_y mode, all hex
// mode bit 0 fifo stalls, bit 1 retrigger and next color mid-circle, bit 2 keep stored color
ff8000 100 0c8 000 00400000 04 100 0c8 0
00ff00 064 064 005 0fc00000 24 065 069 0
123456 064 064 005 00800000 24 068 061 1
abcdef 005 3fc 00a ffc00000 3c 3fb 3fc 1
000001 200 200 001 01400000 0c 1ff 200 1
55aa55 1f3 123 00a 02000000 3c 1ec 11c 3
c0ffee 3ff 000 003 00000000 14 001 002 5
7f7f7f 080 300 002 0c000000 14 082 2ff 1

//--- src.f
gfx_pkg.sv
circle_regs.sv
circle_engine.sv
pixel_writer.sv
circle_top.sv
circle_asserts.sv
circle_tb.sv
